// ==== rvseed_pkg.sv ====
package rvseed_pkg;

    localparam int xlen = 64;

    // operation codes handed over by execute
    localparam logic [2:0] op_none  = 3'd0;
    localparam logic [2:0] op_load  = 3'd1;
    localparam logic [2:0] op_csrrw = 3'd2;
    localparam logic [2:0] op_csrrs = 3'd3;
    localparam logic [2:0] op_ecall = 3'd4;
    localparam logic [2:0] op_mret  = 3'd5;

    // load kinds, signed ones first
    localparam logic [2:0] ld_b  = 3'd0;
    localparam logic [2:0] ld_h  = 3'd1;
    localparam logic [2:0] ld_w  = 3'd2;
    localparam logic [2:0] ld_d  = 3'd3;
    localparam logic [2:0] ld_bu = 3'd4;
    localparam logic [2:0] ld_hu = 3'd5;
    localparam logic [2:0] ld_wu = 3'd6;

    // machine-mode csr numbers
    localparam logic [11:0] csr_mstatus = 12'h300;
    localparam logic [11:0] csr_mtvec   = 12'h305;
    localparam logic [11:0] csr_mepc    = 12'h341;
    localparam logic [11:0] csr_mcause  = 12'h342;

    // clint registers seen through mmio
    localparam logic [xlen-1:0] clint_mtimecmp_addr = 64'h0000_0000_0200_4000;
    localparam logic [xlen-1:0] clint_mtime_addr    = 64'h0000_0000_0200_BFF8;

    localparam logic [xlen-1:0] mstatus_reset = 64'h0000_0000_A000_1800;
    localparam logic [xlen-1:0] mtvec_reset   = 64'h0000_0000_8000_0100;
    localparam logic [xlen-1:0] cause_ecall   = 64'd11;
    // interrupt bit plus machine timer code
    localparam logic [xlen-1:0] cause_timer   = 64'h8000_0000_0000_0007;

    // access fsm encoding
    localparam logic [2:0] st_idle     = 3'd0;
    localparam logic [2:0] st_mem      = 3'd1;
    localparam logic [2:0] st_wait     = 3'd2;
    localparam logic [2:0] st_mmio     = 3'd3;
    localparam logic [2:0] st_csr      = 3'd4;
    localparam logic [2:0] st_redirect = 3'd5;
    localparam logic [2:0] st_done     = 3'd6;

    // raw word for csr access, fields for trap entry and return
    typedef union packed {
        logic [xlen-1:0] raw;
        struct packed {
            logic [55:0] fill_hi;
            logic        mpie;
            logic [2:0]  fill_mid;
            logic        mie;
            logic [2:0]  fill_lo;
        } f;
    } mstatus_u;

endpackage

// ==== load_align.sv ====
`timescale 1ns/1ns

module load_align (
    input  logic [rvseed_pkg::xlen-1:0] raw,
    input  logic [2:0]                  load_kind,
    input  logic [2:0]                  byte_off,
    output logic [rvseed_pkg::xlen-1:0] data
);

    logic [rvseed_pkg::xlen-1:0] shifted;

    // move the addressed byte down to lane 0
    assign shifted = raw >> {byte_off, 3'b000};

    always_comb begin
        case (load_kind)
            rvseed_pkg::ld_b: begin
                data = {{56{shifted[7]}}, shifted[7:0]};
            end
            rvseed_pkg::ld_h: begin
                data = {{48{shifted[15]}}, shifted[15:0]};
            end
            rvseed_pkg::ld_w: begin
                data = {{32{shifted[31]}}, shifted[31:0]};
            end
            rvseed_pkg::ld_d: begin
                data = shifted;
            end
            rvseed_pkg::ld_bu: begin
                data = {56'd0, shifted[7:0]};
            end
            rvseed_pkg::ld_hu: begin
                data = {48'd0, shifted[15:0]};
            end
            rvseed_pkg::ld_wu: begin
                data = {32'd0, shifted[31:0]};
            end
            default: begin
                // unused code, pass the full doubleword
                data = shifted;
            end
        endcase
    end

endmodule

// ==== mem_clint.sv ====
`timescale 1ns/1ns

module mem_clint (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [rvseed_pkg::xlen-1:0] mmio_addr,
    input  logic [rvseed_pkg::xlen-1:0] mtimecmp,
    output logic [rvseed_pkg::xlen-1:0] mmio_rdata,
    output logic                        timer_pending
);

    logic [rvseed_pkg::xlen-1:0] mtime;

    // free-running machine timer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    // level signal, stays up until mtimecmp is moved past mtime
    assign timer_pending = (mtime >= mtimecmp);

    // mmio read mux, answered in the same cycle
    always_comb begin
        case (mmio_addr)
            rvseed_pkg::clint_mtimecmp_addr: begin
                mmio_rdata = mtimecmp;
            end
            rvseed_pkg::clint_mtime_addr: begin
                mmio_rdata = mtime;
            end
            default: begin
                mmio_rdata = '0;
            end
        endcase
    end

endmodule

// ==== csr_trap_unit.sv ====
`timescale 1ns/1ns

module csr_trap_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        csr_we,
    input  logic                        csr_set,
    input  logic [11:0]                 csr_addr,
    input  logic [rvseed_pkg::xlen-1:0] csr_wdata,
    input  logic                        trap_irq,
    input  logic                        trap_ecall,
    input  logic                        trap_mret,
    input  logic [rvseed_pkg::xlen-1:0] pc,
    input  logic                        timer_pending,
    output logic [rvseed_pkg::xlen-1:0] csr_rdata,
    output logic                        irq_take,
    output logic [rvseed_pkg::xlen-1:0] mtvec,
    output logic [rvseed_pkg::xlen-1:0] mepc,
    output rvseed_pkg::mstatus_u        mstatus
);

    logic [rvseed_pkg::xlen-1:0] mcause;
    logic [rvseed_pkg::xlen-1:0] csr_wval;

    // old value of the addressed csr
    always_comb begin
        case (csr_addr)
            rvseed_pkg::csr_mstatus: begin
                csr_rdata = mstatus.raw;
            end
            rvseed_pkg::csr_mtvec: begin
                csr_rdata = mtvec;
            end
            rvseed_pkg::csr_mepc: begin
                csr_rdata = mepc;
            end
            rvseed_pkg::csr_mcause: begin
                csr_rdata = mcause;
            end
            default: begin
                csr_rdata = '0;
            end
        endcase
    end

    // csrrs merges, csrrw replaces
    assign csr_wval = csr_set ? (csr_rdata | csr_wdata) : csr_wdata;

    // only the machine timer can interrupt
    assign irq_take = timer_pending & mstatus.f.mie;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus.raw <= rvseed_pkg::mstatus_reset;
            mtvec       <= rvseed_pkg::mtvec_reset;
            mepc        <= '0;
            mcause      <= '0;
        end else if (trap_irq || trap_ecall) begin
            // trap entry
            mepc           <= pc;
            mcause         <= trap_irq ? rvseed_pkg::cause_timer : rvseed_pkg::cause_ecall;
            mstatus.f.mpie <= mstatus.f.mie;
            mstatus.f.mie  <= 1'b0;
        end else if (trap_mret) begin
            mstatus.f.mie  <= mstatus.f.mpie;
            mstatus.f.mpie <= 1'b1;
        end else if (csr_we) begin
            case (csr_addr)
                rvseed_pkg::csr_mstatus: begin
                    mstatus.raw <= csr_wval;
                end
                rvseed_pkg::csr_mtvec: begin
                    mtvec <= csr_wval;
                end
                rvseed_pkg::csr_mepc: begin
                    mepc <= csr_wval;
                end
                rvseed_pkg::csr_mcause: begin
                    mcause <= csr_wval;
                end
                default: begin
                    // unknown csr, write dropped
                    mcause <= mcause;
                end
            endcase
        end
    end

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    input  logic [2:0]                  op,
    input  logic [2:0]                  load_kind,
    input  logic [rvseed_pkg::xlen-1:0] src1,
    input  logic [rvseed_pkg::xlen-1:0] src2,
    input  logic [11:0]                 csr_addr,
    input  logic [rvseed_pkg::xlen-1:0] pc,
    output logic                        busy,
    output logic                        res_valid,
    output logic [rvseed_pkg::xlen-1:0] res_data,
    output logic                        bus_ar_valid,
    output logic [rvseed_pkg::xlen-1:0] bus_addr,
    input  logic                        bus_r_valid,
    input  logic [rvseed_pkg::xlen-1:0] bus_rdata,
    output logic [rvseed_pkg::xlen-1:0] mmio_addr,
    output logic                        csr_we,
    output logic                        csr_set,
    output logic [11:0]                 csr_addr_q,
    output logic [rvseed_pkg::xlen-1:0] csr_wdata,
    output logic                        trap_irq,
    output logic                        trap_ecall,
    output logic                        trap_mret,
    output logic [rvseed_pkg::xlen-1:0] pc_q,
    input  logic [rvseed_pkg::xlen-1:0] mmio_rdata,
    input  logic [rvseed_pkg::xlen-1:0] csr_rdata,
    input  logic                        irq_take,
    input  logic [rvseed_pkg::xlen-1:0] mtvec,
    input  logic [rvseed_pkg::xlen-1:0] mepc,
    output logic                        redirect_valid,
    output logic [rvseed_pkg::xlen-1:0] redirect_pc
);

    logic [2:0]                  state;
    logic [2:0]                  state_nxt;
    logic [2:0]                  kind_q;
    logic [rvseed_pkg::xlen-1:0] addr_q;
    logic [rvseed_pkg::xlen-1:0] res_q;
    logic [rvseed_pkg::xlen-1:0] eff_addr;
    logic [rvseed_pkg::xlen-1:0] align_raw;
    logic [rvseed_pkg::xlen-1:0] align_data;
    logic                        accept;
    logic                        exec;
    logic                        is_clint;

    assign eff_addr = src1 + src2;
    assign accept   = req_valid && !busy;
    // a pending interrupt replaces the instruction
    assign exec     = accept && !irq_take;
    assign is_clint = (eff_addr == rvseed_pkg::clint_mtimecmp_addr) ||
                      (eff_addr == rvseed_pkg::clint_mtime_addr);

    always_comb begin
        state_nxt = state;
        case (state)
            rvseed_pkg::st_idle: begin
                if (accept && irq_take) begin
                    state_nxt = rvseed_pkg::st_redirect;
                end else if (accept) begin
                    case (op)
                        rvseed_pkg::op_load: begin
                            state_nxt = is_clint ? rvseed_pkg::st_mmio : rvseed_pkg::st_mem;
                        end
                        rvseed_pkg::op_csrrw, rvseed_pkg::op_csrrs: begin
                            state_nxt = rvseed_pkg::st_csr;
                        end
                        rvseed_pkg::op_ecall, rvseed_pkg::op_mret: begin
                            state_nxt = rvseed_pkg::st_redirect;
                        end
                        rvseed_pkg::op_none: begin
                            state_nxt = rvseed_pkg::st_idle;
                        end
                        default: begin
                            state_nxt = rvseed_pkg::st_idle;
                        end
                    endcase
                end
            end
            rvseed_pkg::st_mem: begin
                state_nxt = rvseed_pkg::st_wait;
            end
            rvseed_pkg::st_wait: begin
                // latency is open-ended, just sit here
                if (bus_r_valid) begin
                    state_nxt = rvseed_pkg::st_done;
                end
            end
            rvseed_pkg::st_mmio: begin
                state_nxt = rvseed_pkg::st_done;
            end
            default: begin
                state_nxt = rvseed_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= rvseed_pkg::st_idle;
            csr_we     <= 1'b0;
            csr_set    <= 1'b0;
            trap_irq   <= 1'b0;
            trap_ecall <= 1'b0;
            trap_mret  <= 1'b0;
        end else begin
            state      <= state_nxt;
            csr_we     <= exec && (op == rvseed_pkg::op_csrrw || op == rvseed_pkg::op_csrrs);
            csr_set    <= exec && (op == rvseed_pkg::op_csrrs);
            trap_irq   <= accept && irq_take;
            trap_ecall <= exec && (op == rvseed_pkg::op_ecall);
            trap_mret  <= exec && (op == rvseed_pkg::op_mret);
        end
    end

    // request payload, held for the whole access
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q     <= eff_addr;
            kind_q     <= load_kind;
            csr_addr_q <= csr_addr;
            csr_wdata  <= src1;
            pc_q       <= pc;
        end
        if ((state == rvseed_pkg::st_wait && bus_r_valid) || state == rvseed_pkg::st_mmio) begin
            res_q <= align_data;
        end
    end

    assign align_raw = (state == rvseed_pkg::st_mmio) ? mmio_rdata : bus_rdata;

    load_align u_load_align (
        .raw       (align_raw),
        .load_kind (kind_q),
        .byte_off  (addr_q[2:0]),
        .data      (align_data)
    );

    assign busy           = (state != rvseed_pkg::st_idle);
    assign bus_ar_valid   = (state == rvseed_pkg::st_mem);
    assign bus_addr       = addr_q;
    assign mmio_addr      = addr_q;
    assign res_valid      = (state == rvseed_pkg::st_done) || (state == rvseed_pkg::st_csr);
    // csr result is the old value, read before the write edge
    assign res_data       = (state == rvseed_pkg::st_csr) ? csr_rdata : res_q;
    assign redirect_valid = (state == rvseed_pkg::st_redirect);
    assign redirect_pc    = trap_mret ? mepc : mtvec;

endmodule

// ==== mem_subsystem.sv ====
`timescale 1ns/1ns

module mem_subsystem (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    input  logic [2:0]                  op,
    input  logic [2:0]                  load_kind,
    input  logic [rvseed_pkg::xlen-1:0] src1,
    input  logic [rvseed_pkg::xlen-1:0] src2,
    input  logic [11:0]                 csr_addr,
    input  logic [rvseed_pkg::xlen-1:0] pc,
    output logic                        busy,
    output logic                        res_valid,
    output logic [rvseed_pkg::xlen-1:0] res_data,
    output logic                        bus_ar_valid,
    output logic [rvseed_pkg::xlen-1:0] bus_addr,
    input  logic                        bus_r_valid,
    input  logic [rvseed_pkg::xlen-1:0] bus_rdata,
    output logic                        redirect_valid,
    output logic [rvseed_pkg::xlen-1:0] redirect_pc,
    input  logic [rvseed_pkg::xlen-1:0] mtimecmp,
    output rvseed_pkg::mstatus_u        mstatus
);

    logic [rvseed_pkg::xlen-1:0] mmio_addr;
    logic [rvseed_pkg::xlen-1:0] mmio_rdata;
    logic                        timer_pending;
    logic                        csr_we;
    logic                        csr_set;
    logic [11:0]                 csr_addr_q;
    logic [rvseed_pkg::xlen-1:0] csr_wdata;
    logic [rvseed_pkg::xlen-1:0] csr_rdata;
    logic                        trap_irq;
    logic                        trap_ecall;
    logic                        trap_mret;
    logic [rvseed_pkg::xlen-1:0] pc_q;
    logic                        irq_take;
    logic [rvseed_pkg::xlen-1:0] mtvec;
    logic [rvseed_pkg::xlen-1:0] mepc;

    mem_stage u_mem_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .op             (op),
        .load_kind      (load_kind),
        .src1           (src1),
        .src2           (src2),
        .csr_addr       (csr_addr),
        .pc             (pc),
        .busy           (busy),
        .res_valid      (res_valid),
        .res_data       (res_data),
        .bus_ar_valid   (bus_ar_valid),
        .bus_addr       (bus_addr),
        .bus_r_valid    (bus_r_valid),
        .bus_rdata      (bus_rdata),
        .mmio_addr      (mmio_addr),
        .csr_we         (csr_we),
        .csr_set        (csr_set),
        .csr_addr_q     (csr_addr_q),
        .csr_wdata      (csr_wdata),
        .trap_irq       (trap_irq),
        .trap_ecall     (trap_ecall),
        .trap_mret      (trap_mret),
        .pc_q           (pc_q),
        .mmio_rdata     (mmio_rdata),
        .csr_rdata      (csr_rdata),
        .irq_take       (irq_take),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    mem_clint u_mem_clint (
        .clk           (clk),
        .rst_n         (rst_n),
        .mmio_addr     (mmio_addr),
        .mtimecmp      (mtimecmp),
        .mmio_rdata    (mmio_rdata),
        .timer_pending (timer_pending)
    );

    csr_trap_unit u_csr_trap_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_we        (csr_we),
        .csr_set       (csr_set),
        .csr_addr      (csr_addr_q),
        .csr_wdata     (csr_wdata),
        .trap_irq      (trap_irq),
        .trap_ecall    (trap_ecall),
        .trap_mret     (trap_mret),
        .pc            (pc_q),
        .timer_pending (timer_pending),
        .csr_rdata     (csr_rdata),
        .irq_take      (irq_take),
        .mtvec         (mtvec),
        .mepc          (mepc),
        .mstatus       (mstatus)
    );

endmodule

// ==== mem_subsystem_assertions.sv ====
`timescale 1ns/1ns

module mem_subsystem_assertions (
    input logic                        clk,
    input logic                        rst_n,
    input logic [2:0]                  state,
    input logic                        bus_ar_valid,
    input logic [rvseed_pkg::xlen-1:0] bus_addr,
    input logic                        res_valid,
    input logic                        redirect_valid
);

    int fail_count = 0;

    // read strobe is a single-cycle pulse
    ar_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        bus_ar_valid |=> !bus_ar_valid)
    else begin
        fail_count++;
        $error("bus_ar_valid high in two consecutive cycles");
    end

    // one outcome per instruction, then quiet for a cycle
    res_redirect_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        (res_valid || redirect_valid) |-> !(res_valid && redirect_valid)
            ##1 !(res_valid || redirect_valid))
    else begin
        fail_count++;
        $error("result and redirect pulses not single and exclusive");
    end

    // address held until the memory answers
    addr_stable_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        (state == rvseed_pkg::st_wait) |-> $stable(bus_addr))
    else begin
        fail_count++;
        $error("bus_addr changed while waiting for the read response");
    end

endmodule

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/1ns

module tb_mem_subsystem;

    localparam int          clk_period    = 40;
    localparam int          reset_cycles  = 16;
    localparam logic [31:0] seed          = 32'd11;
    localparam int          result_limit  = 8;
    // 81 requests in the directed tests, each at most this many cycles
    localparam int          request_count = 81;
    localparam int          max_latency   = 12;
    localparam logic [63:0] no_timer      = '1;
    localparam int          i_mstatus     = 0;
    localparam int          i_mtvec       = 1;
    localparam int          i_mepc        = 2;
    localparam int          i_mcause      = 3;
    localparam logic [11:0] csr_list [4]  = '{rvseed_pkg::csr_mstatus, rvseed_pkg::csr_mtvec,
                                              rvseed_pkg::csr_mepc, rvseed_pkg::csr_mcause};

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic [2:0]  op;
    logic [2:0]  load_kind;
    logic [63:0] src1;
    logic [63:0] src2;
    logic [11:0] csr_addr;
    logic [63:0] pc;
    logic        busy;
    logic        res_valid;
    logic [63:0] res_data;
    logic        bus_ar_valid;
    logic [63:0] bus_addr;
    logic        bus_r_valid;
    logic [63:0] bus_rdata;
    logic        redirect_valid;
    logic [63:0] redirect_pc;
    logic [63:0] mtimecmp;
    logic [63:0] mstatus;

    int          error_count;
    int          check_count;
    int          assert_fails;
    logic [63:0] cycles;
    logic [31:0] test_state;
    logic [31:0] mem_state;
    logic [63:0] model_csr [4];
    // outcome of the last request
    logic [63:0] r_data;
    logic        r_redir;
    int          r_lat;
    logic        r_bus_seen;
    logic [63:0] r_bus_addr;

    mem_subsystem uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .op             (op),
        .load_kind      (load_kind),
        .src1           (src1),
        .src2           (src2),
        .csr_addr       (csr_addr),
        .pc             (pc),
        .busy           (busy),
        .res_valid      (res_valid),
        .res_data       (res_data),
        .bus_ar_valid   (bus_ar_valid),
        .bus_addr       (bus_addr),
        .bus_r_valid    (bus_r_valid),
        .bus_rdata      (bus_rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .mtimecmp       (mtimecmp),
        .mstatus        (mstatus)
    );

    bind mem_stage mem_subsystem_assertions u_mem_assert (
        .clk            (clk),
        .rst_n          (rst_n),
        .state          (state),
        .bus_ar_valid   (bus_ar_valid),
        .bus_addr       (bus_addr),
        .res_valid      (res_valid),
        .redirect_valid (redirect_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // mirrors mtime, clock edges since reset release
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycles <= '0;
        end else begin
            cycles <= cycles + 1'b1;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // memory contents, a mix of the whole doubleword address
    function automatic logic [63:0] pattern_word(input logic [63:0] addr);
        logic [63:0] base;
        base = {addr[63:3], 3'b000};
        return (base * 64'h9E37_79B9_7F4A_7C15) ^ {base[31:0], base[63:32]};
    endfunction

    // bytes from off upward, missing bytes read as zero, then extension
    function automatic logic [63:0] expect_load(input logic [63:0] word, input logic [2:0] kind,
                                                input int off);
        int          nbytes;
        logic        is_signed;
        logic [63:0] v;
        case (kind)
            rvseed_pkg::ld_b, rvseed_pkg::ld_bu: nbytes = 1;
            rvseed_pkg::ld_h, rvseed_pkg::ld_hu: nbytes = 2;
            rvseed_pkg::ld_w, rvseed_pkg::ld_wu: nbytes = 4;
            default: nbytes = 8;
        endcase
        is_signed = (kind == rvseed_pkg::ld_b) || (kind == rvseed_pkg::ld_h) ||
                    (kind == rvseed_pkg::ld_w);
        v = '0;
        for (int i = 0; i < nbytes; i++) begin
            if (off + i < 8) begin
                v[8*i +: 8] = word[8*(off+i) +: 8];
            end
        end
        if (is_signed && v[8*nbytes-1]) begin
            for (int i = nbytes; i < 8; i++) begin
                v[8*i +: 8] = 8'hFF;
            end
        end
        return v;
    endfunction

    // mie (bit 3) moves into mpie (bit 7) on trap entry
    function automatic logic [63:0] enter_trap_status(input logic [63:0] s);
        logic [63:0] r;
        r = s;
        r[7] = s[3];
        r[3] = 1'b0;
        return r;
    endfunction

    function automatic logic [63:0] leave_trap_status(input logic [63:0] s);
        logic [63:0] r;
        r = s;
        r[3] = s[7];
        r[7] = 1'b1;
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // issue one request and wait for its result or redirect pulse
    task automatic run_op(input logic [2:0] op_i, input logic [2:0] kind_i, input logic [63:0] s1,
                          input logic [63:0] s2, input logic [11:0] csr_i,
                          input logic [63:0] pc_i);
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        req_valid = 1'b1;
        op        = op_i;
        load_kind = kind_i;
        src1      = s1;
        src2      = s2;
        csr_addr  = csr_i;
        pc        = pc_i;
        @(negedge clk);
        req_valid  = 1'b0;
        r_lat      = 0;
        // every cycle up to and including the pulse is watched for a strobe
        r_bus_seen = bus_ar_valid;
        r_bus_addr = bus_addr;
        while (!res_valid && !redirect_valid && r_lat < result_limit) begin
            @(negedge clk);
            r_lat++;
            if (bus_ar_valid) begin
                r_bus_seen = 1'b1;
                r_bus_addr = bus_addr;
            end
        end
        if (!res_valid && !redirect_valid) begin
            report_failure("request got neither a result nor a redirect pulse");
        end else begin
            check_value("busy with result pulse", busy, 1);
        end
        r_redir = redirect_valid;
        r_data  = redirect_valid ? redirect_pc : res_data;
    endtask

    task automatic csr_access(input logic [2:0] op_i, input int idx, input logic [63:0] wdata);
        run_op(op_i, rvseed_pkg::ld_d, wdata, 64'd0, csr_list[idx], 64'd0);
        check_value($sformatf("csr %h res_data", csr_list[idx]), r_data, model_csr[idx]);
        check_value("csr result latency", r_lat, 0);
        check_value("csr redirect_valid", r_redir, 0);
        model_csr[idx] = (op_i == rvseed_pkg::op_csrrw) ? wdata : (model_csr[idx] | wdata);
    endtask

    task automatic load_lanes();
        logic [63:0] addr;
        logic [63:0] s1;
        for (int off = 0; off < 8; off++) begin
            for (int kind = 0; kind < 7; kind++) begin
                test_state = lcg_next(test_state);
                addr = {32'h0000_0001, test_state[31:3], 3'(off)};
                test_state = lcg_next(test_state);
                s1 = {32'd0, test_state};
                run_op(rvseed_pkg::op_load, 3'(kind), s1, addr - s1, 12'd0, addr);
                check_value("bus request seen", r_bus_seen, 1);
                check_value("bus_addr", r_bus_addr, addr);
                check_value("load redirect_valid", r_redir, 0);
                check_value($sformatf("res_data kind %0d offset %0d", kind, off), r_data,
                            expect_load(pattern_word(addr), 3'(kind), off));
            end
        end
    endtask

    task automatic clint_reads();
        logic [63:0] first;
        run_op(rvseed_pkg::op_load, rvseed_pkg::ld_d, 64'h0200_BF00, 64'hF8, 12'd0, 64'd0);
        check_value("clint load latency", r_lat, 1);
        check_value("clint bus request seen", r_bus_seen, 0);
        first = r_data;
        if (first > cycles) begin
            report_failure("mtime read is ahead of the cycles since reset");
        end
        run_op(rvseed_pkg::op_load, rvseed_pkg::ld_d, 64'h0200_BFF8, 64'd0, 12'd0, 64'd0);
        if (r_data <= first || r_data > cycles) begin
            report_failure("second mtime read did not advance within the cycles since reset");
        end
        mtimecmp = 64'h7654_3210_0123_4567;
        run_op(rvseed_pkg::op_load, rvseed_pkg::ld_d, 64'h0200_3000, 64'h1000, 12'd0, 64'd0);
        check_value("mtimecmp read", r_data, 64'h7654_3210_0123_4567);
        mtimecmp = no_timer;
    endtask

    task automatic csr_write_set();
        logic [63:0] wval;
        logic [63:0] sval;
        for (int i = 0; i < 4; i++) begin
            test_state = lcg_next(test_state);
            wval = {test_state, ~test_state};
            test_state = lcg_next(test_state);
            sval = {~test_state, test_state};
            csr_access(rvseed_pkg::op_csrrw, i, wval);
            csr_access(rvseed_pkg::op_csrrs, i, sval);
            csr_access(rvseed_pkg::op_csrrs, i, 64'd0);
        end
    endtask

    task automatic ecall_mret();
        logic [63:0] trap_pc;
        trap_pc = 64'h0000_0000_8000_2468;
        csr_access(rvseed_pkg::op_csrrw, i_mtvec, 64'h0000_0000_8000_0400);
        csr_access(rvseed_pkg::op_csrrs, i_mstatus, 64'h8);
        run_op(rvseed_pkg::op_ecall, rvseed_pkg::ld_d, 64'd0, 64'd0, 12'd0, trap_pc);
        check_value("ecall redirect_valid", r_redir, 1);
        check_value("ecall redirect latency", r_lat, 0);
        check_value("ecall redirect_pc", r_data, model_csr[i_mtvec]);
        model_csr[i_mepc]    = trap_pc;
        model_csr[i_mcause]  = 64'd11;
        model_csr[i_mstatus] = enter_trap_status(model_csr[i_mstatus]);
        @(negedge clk);
        check_value("mstatus after ecall", mstatus, model_csr[i_mstatus]);
        csr_access(rvseed_pkg::op_csrrs, i_mepc, 64'd0);
        csr_access(rvseed_pkg::op_csrrs, i_mcause, 64'd0);
        run_op(rvseed_pkg::op_mret, rvseed_pkg::ld_d, 64'd0, 64'd0, 12'd0, 64'd0);
        check_value("mret redirect_valid", r_redir, 1);
        check_value("mret redirect_pc", r_data, trap_pc);
        model_csr[i_mstatus] = leave_trap_status(model_csr[i_mstatus]);
        @(negedge clk);
        check_value("mstatus after mret", mstatus, model_csr[i_mstatus]);
    endtask

    task automatic timer_interrupt();
        logic [63:0] irq_pc;
        irq_pc = 64'h0000_0000_8000_1234;
        csr_access(rvseed_pkg::op_csrrs, i_mstatus, 64'h8);
        mtimecmp = 64'd0;
        run_op(rvseed_pkg::op_load, rvseed_pkg::ld_d, 64'h1_0000_0000, 64'h40, 12'd0, irq_pc);
        check_value("interrupt redirect_valid", r_redir, 1);
        check_value("interrupt redirect latency", r_lat, 0);
        check_value("interrupt redirect_pc", r_data, model_csr[i_mtvec]);
        check_value("interrupt bus request seen", r_bus_seen, 0);
        model_csr[i_mepc]    = irq_pc;
        model_csr[i_mcause]  = 64'h8000_0000_0000_0007;
        model_csr[i_mstatus] = enter_trap_status(model_csr[i_mstatus]);
        // the replaced load must stay silent
        repeat (3) begin
            @(negedge clk);
            check_value("res_valid after interrupt", res_valid, 0);
            check_value("bus_ar_valid after interrupt", bus_ar_valid, 0);
        end
        mtimecmp = no_timer;
        check_value("mstatus after interrupt", mstatus, model_csr[i_mstatus]);
        csr_access(rvseed_pkg::op_csrrs, i_mcause, 64'd0);
        csr_access(rvseed_pkg::op_csrrs, i_mepc, 64'd0);
    endtask

    // answers each read strobe after 1 to 4 cycles
    initial begin : memory_model
        logic [63:0] req_addr;
        int          delay;
        mem_state = seed;
        forever begin
            @(negedge clk);
            if (bus_ar_valid) begin
                req_addr  = bus_addr;
                mem_state = lcg_next(mem_state);
                delay     = 1 + int'(mem_state[17:16]);
                repeat (delay) @(negedge clk);
                bus_r_valid = 1'b1;
                bus_rdata   = pattern_word(req_addr);
                @(negedge clk);
                bus_r_valid = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #((reset_cycles + request_count * max_latency) * clk_period);
        $display("Error at %0t ns: watchdog expired before the tests finished", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        op          = rvseed_pkg::op_none;
        load_kind   = rvseed_pkg::ld_d;
        src1        = '0;
        src2        = '0;
        csr_addr    = '0;
        pc          = '0;
        bus_r_valid = 1'b0;
        bus_rdata   = '0;
        mtimecmp    = no_timer;
        error_count = 0;
        check_count = 0;
        test_state  = seed;
        model_csr[i_mstatus] = 64'h0000_0000_A000_1800;
        model_csr[i_mtvec]   = 64'h0000_0000_8000_0100;
        model_csr[i_mepc]    = 64'd0;
        model_csr[i_mcause]  = 64'd0;
        repeat (reset_cycles) @(negedge clk);
        check_value("busy in reset", busy, 0);
        check_value("res_valid in reset", res_valid, 0);
        check_value("redirect_valid in reset", redirect_valid, 0);
        check_value("bus_ar_valid in reset", bus_ar_valid, 0);
        rst_n = 1'b1;
        load_lanes();
        clint_reads();
        csr_write_set();
        ecall_mret();
        timer_interrupt();
        repeat (2) @(negedge clk);
        assert_fails = uut.u_mem_stage.u_mem_assert.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== mem_subsystem.f ====
rvseed_pkg.sv
load_align.sv
mem_clint.sv
csr_trap_unit.sv
mem_stage.sv
mem_subsystem.sv
mem_subsystem_assertions.sv
tb_mem_subsystem.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - rvseed_pkg.sv
  - load_align.sv
  - mem_clint.sv
  - csr_trap_unit.sv
  - mem_stage.sv
  - mem_subsystem.sv
  - target: test
    files:
      - mem_subsystem_assertions.sv
      - tb_mem_subsystem.sv
